// ==== verilog/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

  // Data path width, one machine word
  localparam int XLEN = 32;

  typedef logic [11:0] csr_addr_t;

  // Machine trap setup and handling
  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MIE     = 12'h304;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MIP     = 12'h344;

  // Machine counters, low and high halves
  localparam csr_addr_t CSR_MCYCLE    = 12'hB00;
  localparam csr_addr_t CSR_MINSTRET  = 12'hB02;
  localparam csr_addr_t CSR_MCYCLEH   = 12'hB80;
  localparam csr_addr_t CSR_MINSTRETH = 12'hB82;

  // Machine information registers, read only
  localparam csr_addr_t CSR_MVENDORID = 12'hF11;
  localparam csr_addr_t CSR_MARCHID   = 12'hF12;
  localparam csr_addr_t CSR_MIMPID    = 12'hF13;
  localparam csr_addr_t CSR_MHARTID   = 12'hF14;

  // Field positions
  localparam int MIE_BIT  = 3;   // mstatus.MIE
  localparam int MPIE_BIT = 7;   // mstatus.MPIE
  localparam int MPP_LSB  = 11;  // mstatus.MPP, two bits wide
  localparam int MEIE_BIT = 11;  // mie.MEIE
  localparam int MEIP_BIT = 11;  // mip.MEIP

  localparam logic [XLEN-1:0] CSR_ZERO = '0;

  // CSR access opcodes, one cycle strobe
  typedef enum logic [1:0] {
    CSR_NONE  = 2'b00,
    CSR_WRITE = 2'b01,
    CSR_SET   = 2'b10,
    CSR_CLEAR = 2'b11
  } csr_op_e;

  // Trap sequencer states
  typedef enum logic [1:0] {
    ST_RUN  = 2'b00,
    ST_TRAP = 2'b01,
    ST_RET  = 2'b10
  } trap_state_e;

endpackage

`default_nettype wire

// ==== verilog/csr_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface csr_ctrl_if;

  logic                     take_trap;    // Apply trap update this cycle
  logic                     take_ret;     // Apply mret update this cycle
  logic                     irq_pending;  // MEIP & MEIE & mstatus.MIE
  logic [csr_pkg::XLEN-1:0] mtvec;
  logic [csr_pkg::XLEN-1:0] mepc;

  // Sequencer side
  modport fsm (
    output take_trap,
    output take_ret,
    input  irq_pending,
    input  mtvec,
    input  mepc
  );

  // Register file side
  modport regfile (
    input  take_trap,
    input  take_ret,
    output irq_pending,
    output mtvec,
    output mepc
  );

endinterface

`default_nettype wire

// ==== verilog/trap_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module trap_fsm (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     mret_i,
  output logic                     trap_o,
  output logic [csr_pkg::XLEN-1:0] trap_pc_o,
  csr_ctrl_if.fsm                  ctrl
);

  csr_pkg::trap_state_e state;
  csr_pkg::trap_state_e state_nxt;

  // Next state, interrupt wins over mret
  always_comb begin
    state_nxt = state;
    case (state)
      csr_pkg::ST_RUN: begin
        if (ctrl.irq_pending) begin
          state_nxt = csr_pkg::ST_TRAP;
        end else if (mret_i) begin
          state_nxt = csr_pkg::ST_RET;
        end
      end
      csr_pkg::ST_TRAP: state_nxt = csr_pkg::ST_RUN;  // Single cycle in trap
      csr_pkg::ST_RET:  state_nxt = csr_pkg::ST_RUN;
      default:          state_nxt = csr_pkg::ST_RUN;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state     <= csr_pkg::ST_RUN;
      trap_o    <= 1'b0;
      trap_pc_o <= csr_pkg::CSR_ZERO;
    end else begin
      state  <= state_nxt;
      trap_o <= (state == csr_pkg::ST_RUN) && (state_nxt != csr_pkg::ST_RUN);
      // Latch redirect target on leaving RUN
      if (state == csr_pkg::ST_RUN) begin
        if (state_nxt == csr_pkg::ST_TRAP) begin
          trap_pc_o <= ctrl.mtvec;
        end else if (state_nxt == csr_pkg::ST_RET) begin
          trap_pc_o <= ctrl.mepc;
        end
      end
    end
  end

  // Regfile applies the update at the edge ending this cycle
  assign ctrl.take_trap = (state == csr_pkg::ST_TRAP);
  assign ctrl.take_ret  = (state == csr_pkg::ST_RET);

  // Redirect is a strict one cycle pulse
  a_trap_single: assert property (
    @(posedge clk) disable iff (!rstn)
    trap_o |=> !trap_o
  ) else $error("trap_o held for two cycles");

  a_take_onehot: assert property (
    @(posedge clk) disable iff (!rstn)
    !(ctrl.take_trap && ctrl.take_ret)
  ) else $error("take_trap and take_ret high together");

endmodule

`default_nettype wire

// ==== verilog/perf_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module perf_counters (
  input  logic        clk,
  input  logic        rstn,
  input  logic        retire_i,
  output logic [63:0] cycle_count_o,
  output logic [63:0] instret_count_o
);

  logic [63:0] cycle_q;
  logic [63:0] instret_q;

  // Free running cycle counter
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cycle_q <= 64'd0;
    end else begin
      cycle_q <= cycle_q + 64'd1;
    end
  end

  // Counts retire pulses
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      instret_q <= 64'd0;
    end else if (retire_i) begin
      instret_q <= instret_q + 64'd1;
    end
  end

  assign cycle_count_o   = cycle_q;
  assign instret_count_o = instret_q;

  // Monotonic outside reset, 64 bits never wrap in practice
  a_cycle_mono: assert property (
    @(posedge clk) disable iff (!rstn)
    cycle_count_o >= $past(cycle_count_o)
  ) else $error("cycle counter went backwards");

  a_instret_mono: assert property (
    @(posedge clk) disable iff (!rstn)
    instret_count_o >= $past(instret_count_o)
  ) else $error("instret counter went backwards");

endmodule

`default_nettype wire

// ==== verilog/csr_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_regfile #(
  parameter logic [csr_pkg::XLEN-1:0] MTVEC_RESET = 32'h0001_0000,
  parameter logic [csr_pkg::XLEN-1:0] HART_ID     = 32'h0000_0000
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      irq_i,
  input  logic [csr_pkg::XLEN-1:0]  pc_i,
  input  csr_pkg::csr_op_e          csr_op_i,
  input  csr_pkg::csr_addr_t        csr_addr_i,
  input  logic [csr_pkg::XLEN-1:0]  csr_wdata_i,
  input  logic [63:0]               cycle_count_i,
  input  logic [63:0]               instret_count_i,
  output logic [csr_pkg::XLEN-1:0]  csr_rdata_o,
  csr_ctrl_if.regfile               ctrl
);

  localparam logic [csr_pkg::XLEN-1:0] ALIGN_MASK = {{(csr_pkg::XLEN-2){1'b1}}, 2'b00};

  logic                     mstatus_mie;
  logic                     mstatus_mpie;
  logic                     mie_meie;
  logic                     mip_meip;
  logic [csr_pkg::XLEN-1:0] mtvec;
  logic [csr_pkg::XLEN-1:0] mepc;

  logic [csr_pkg::XLEN-1:0] mstatus_rd;
  logic [csr_pkg::XLEN-1:0] mie_rd;
  logic [csr_pkg::XLEN-1:0] mip_rd;
  logic [csr_pkg::XLEN-1:0] mstatus_new;
  logic [csr_pkg::XLEN-1:0] mie_new;

  // Write, set or clear against the old value
  function automatic logic [csr_pkg::XLEN-1:0] apply_op(
    input logic [csr_pkg::XLEN-1:0] old_val,
    input csr_pkg::csr_op_e         op,
    input logic [csr_pkg::XLEN-1:0] wdata
  );
    case (op)
      csr_pkg::CSR_WRITE: return wdata;
      csr_pkg::CSR_SET:   return old_val | wdata;
      csr_pkg::CSR_CLEAR: return old_val & ~wdata;
      default:            return old_val;
    endcase
  endfunction

  // Architectural views of the sparse registers
  always_comb begin
    mstatus_rd                          = csr_pkg::CSR_ZERO;
    mstatus_rd[csr_pkg::MIE_BIT]        = mstatus_mie;
    mstatus_rd[csr_pkg::MPIE_BIT]       = mstatus_mpie;
    mstatus_rd[csr_pkg::MPP_LSB +: 2]   = 2'b11;  // M mode only
    mie_rd                              = csr_pkg::CSR_ZERO;
    mie_rd[csr_pkg::MEIE_BIT]           = mie_meie;
    mip_rd                              = csr_pkg::CSR_ZERO;
    mip_rd[csr_pkg::MEIP_BIT]           = mip_meip;
  end

  assign mstatus_new = apply_op(mstatus_rd, csr_op_i, csr_wdata_i);
  assign mie_new     = apply_op(mie_rd, csr_op_i, csr_wdata_i);

  // Trap and mret take priority over software access
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mstatus_mie  <= 1'b0;
      mstatus_mpie <= 1'b0;
      mepc         <= csr_pkg::CSR_ZERO;
    end else if (ctrl.take_trap) begin
      mstatus_mpie <= mstatus_mie;
      mstatus_mie  <= 1'b0;
      mepc         <= pc_i & ALIGN_MASK;
    end else if (ctrl.take_ret) begin
      mstatus_mie  <= mstatus_mpie;
      mstatus_mpie <= 1'b1;
    end else if (csr_op_i != csr_pkg::CSR_NONE) begin
      if (csr_addr_i == csr_pkg::CSR_MSTATUS) begin
        mstatus_mie  <= mstatus_new[csr_pkg::MIE_BIT];
        mstatus_mpie <= mstatus_new[csr_pkg::MPIE_BIT];
      end
      if (csr_addr_i == csr_pkg::CSR_MEPC) begin
        mepc <= apply_op(mepc, csr_op_i, csr_wdata_i) & ALIGN_MASK;
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mie_meie <= 1'b0;
      mip_meip <= 1'b0;
      mtvec    <= MTVEC_RESET;
    end else begin
      mip_meip <= irq_i;  // One cycle behind the pin
      if (!ctrl.take_trap && !ctrl.take_ret && csr_op_i != csr_pkg::CSR_NONE) begin
        if (csr_addr_i == csr_pkg::CSR_MIE) mie_meie <= mie_new[csr_pkg::MEIE_BIT];
        if (csr_addr_i == csr_pkg::CSR_MTVEC) begin
          mtvec <= apply_op(mtvec, csr_op_i, csr_wdata_i) & ALIGN_MASK;
        end
      end
    end
  end

  assign ctrl.irq_pending = mip_meip & mie_meie & mstatus_mie;
  assign ctrl.mtvec       = mtvec;
  assign ctrl.mepc        = mepc;

  // Read shows pre-update state
  always_comb begin
    case (csr_addr_i)
      csr_pkg::CSR_MSTATUS:   csr_rdata_o = mstatus_rd;
      csr_pkg::CSR_MIE:       csr_rdata_o = mie_rd;
      csr_pkg::CSR_MTVEC:     csr_rdata_o = mtvec;
      csr_pkg::CSR_MEPC:      csr_rdata_o = mepc;
      csr_pkg::CSR_MIP:       csr_rdata_o = mip_rd;
      csr_pkg::CSR_MCYCLE:    csr_rdata_o = cycle_count_i[31:0];
      csr_pkg::CSR_MCYCLEH:   csr_rdata_o = cycle_count_i[63:32];
      csr_pkg::CSR_MINSTRET:  csr_rdata_o = instret_count_i[31:0];
      csr_pkg::CSR_MINSTRETH: csr_rdata_o = instret_count_i[63:32];
      csr_pkg::CSR_MHARTID:   csr_rdata_o = HART_ID;
      default:                csr_rdata_o = csr_pkg::CSR_ZERO;  // IDs read zero too
    endcase
  end

  // mepc stays word aligned across writes and traps
  a_mepc_align: assert property (
    @(posedge clk) disable iff (!rstn)
    mepc[1:0] == 2'b00
  ) else $error("mepc low bits set");

endmodule

`default_nettype wire

// ==== verilog/csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
  parameter logic [csr_pkg::XLEN-1:0] MTVEC_RESET = 32'h0001_0000,
  parameter logic [csr_pkg::XLEN-1:0] HART_ID     = 32'h0000_0000
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     irq_i,       // External interrupt level
  input  logic                     mret_i,
  input  logic                     retire_i,
  input  logic [csr_pkg::XLEN-1:0] pc_i,
  input  csr_pkg::csr_op_e         csr_op_i,
  input  csr_pkg::csr_addr_t       csr_addr_i,
  input  logic [csr_pkg::XLEN-1:0] csr_wdata_i,
  output logic [csr_pkg::XLEN-1:0] csr_rdata_o,
  output logic                     trap_o,      // Redirect strobe
  output logic [csr_pkg::XLEN-1:0] trap_pc_o
);

  logic [63:0] cycle_count;
  logic [63:0] instret_count;

  // Sequencer to register file control
  csr_ctrl_if ctrl_if ();

  trap_fsm trap_fsm_inst (
    .clk       (clk),
    .rstn      (rstn),
    .mret_i    (mret_i),
    .trap_o    (trap_o),
    .trap_pc_o (trap_pc_o),
    .ctrl      (ctrl_if.fsm)
  );

  perf_counters perf_counters_inst (
    .clk             (clk),
    .rstn            (rstn),
    .retire_i        (retire_i),
    .cycle_count_o   (cycle_count),
    .instret_count_o (instret_count)
  );

  csr_regfile #(
    .MTVEC_RESET (MTVEC_RESET),
    .HART_ID     (HART_ID)
  ) csr_regfile_inst (
    .clk             (clk),
    .rstn            (rstn),
    .irq_i           (irq_i),
    .pc_i            (pc_i),
    .csr_op_i        (csr_op_i),
    .csr_addr_i      (csr_addr_i),
    .csr_wdata_i     (csr_wdata_i),
    .cycle_count_i   (cycle_count),
    .instret_count_i (instret_count),
    .csr_rdata_o     (csr_rdata_o),
    .ctrl            (ctrl_if.regfile)
  );

endmodule

`default_nettype wire

// ==== verif/tb_csr_checks.svh ====
`ifndef TB_CSR_CHECKS_SVH
`define TB_CSR_CHECKS_SVH

// Check counters and the running test
int    pass_count = 0;
int    fail_count = 0;
int    test_fail_base = 0;
string test_name = "";

task automatic start_test(input string name);
  test_name = name;
  test_fail_base = fail_count;
endtask

task automatic end_test();
  $display("Test %-12s done with %0d errors", test_name, fail_count - test_fail_base);
endtask

task automatic check_data(input string name, input logic [csr_pkg::XLEN-1:0] exp,
                          input logic [csr_pkg::XLEN-1:0] act);
  if (act === exp) begin
    pass_count++;
  end else begin
    fail_count++;
    $display("Error %s/%s: expected %h, actual %h", test_name, name, exp, act);
  end
endtask

// Target only matters while the redirect strobe is high
task automatic check_trap(input string name, input logic exp_trap,
                          input logic [csr_pkg::XLEN-1:0] exp_pc, input logic act_trap,
                          input logic [csr_pkg::XLEN-1:0] act_pc);
  if (act_trap === exp_trap && (!exp_trap || act_pc === exp_pc)) begin
    pass_count++;
  end else begin
    fail_count++;
    $display("Error %s/%s: expected trap=%b pc=%h, actual trap=%b pc=%h",
             test_name, name, exp_trap, exp_pc, act_trap, act_pc);
  end
endtask

task automatic check_count(input string name, input logic [63:0] exp, input logic [63:0] act);
  if (act === exp) begin
    pass_count++;
  end else begin
    fail_count++;
    $display("Error %s/%s: expected %h, actual %h", test_name, name, exp, act);
  end
endtask

`endif

// ==== verif/tb_csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit;

  localparam logic [csr_pkg::XLEN-1:0] MTVEC_RESET = 32'h0000_2000;
  localparam logic [csr_pkg::XLEN-1:0] HART_ID     = 32'h0000_0005;

  logic                     clk;
  logic                     rstn;
  logic                     irq_i;
  logic                     mret_i;
  logic                     retire_i;
  logic [csr_pkg::XLEN-1:0] pc_i;
  csr_pkg::csr_op_e         csr_op_i;
  csr_pkg::csr_addr_t       csr_addr_i;
  logic [csr_pkg::XLEN-1:0] csr_wdata_i;
  logic [csr_pkg::XLEN-1:0] csr_rdata_o;
  logic                     trap_o;
  logic [csr_pkg::XLEN-1:0] trap_pc_o;

  logic                     irq_lvl;  // Applied at the next drive
  logic [csr_pkg::XLEN-1:0] pc_val;

  // Shadow model state
  logic [csr_pkg::XLEN-1:0] m_mstatus;
  logic [csr_pkg::XLEN-1:0] m_mie;
  logic [csr_pkg::XLEN-1:0] m_mip;
  logic [csr_pkg::XLEN-1:0] m_mtvec;
  logic [csr_pkg::XLEN-1:0] m_mepc;
  logic [63:0]              m_cycles;
  logic [63:0]              m_retires;
  logic                     m_trap_q;
  logic                     m_ret_q;
  logic [csr_pkg::XLEN-1:0] m_trap_pc;

  integer                   seed;
  int                       i;
  int                       op_sel;
  csr_pkg::csr_op_e         rnd_op;
  csr_pkg::csr_addr_t       rnd_addr;
  logic [63:0]              act64;
  logic [63:0]              exp64;
  logic [csr_pkg::XLEN-1:0] a0;
  logic [csr_pkg::XLEN-1:0] a1;
  logic [csr_pkg::XLEN-1:0] exp_vec;
  logic                     found;

  `include "tb_csr_checks.svh"

  csr_unit #(.MTVEC_RESET(MTVEC_RESET), .HART_ID(HART_ID)) csr_unit_inst (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Expected register value after a write, set or clear
  function automatic logic [csr_pkg::XLEN-1:0] ref_csr_next(
    input logic [csr_pkg::XLEN-1:0] old_val,
    input csr_pkg::csr_op_e         op,
    input csr_pkg::csr_addr_t       addr,
    input logic [csr_pkg::XLEN-1:0] wdata
  );
    logic [csr_pkg::XLEN-1:0] raw;
    logic [csr_pkg::XLEN-1:0] mask;  // Writable bits only
    case (op)
      csr_pkg::CSR_WRITE: raw = wdata;
      csr_pkg::CSR_SET:   raw = old_val | wdata;
      csr_pkg::CSR_CLEAR: raw = old_val & ~wdata;
      default:            raw = old_val;
    endcase
    case (addr)
      csr_pkg::CSR_MSTATUS: mask = (32'h1 << csr_pkg::MIE_BIT) | (32'h1 << csr_pkg::MPIE_BIT);
      csr_pkg::CSR_MIE:     mask = 32'h1 << csr_pkg::MEIE_BIT;
      csr_pkg::CSR_MTVEC:   mask = 32'hFFFF_FFFC;
      csr_pkg::CSR_MEPC:    mask = 32'hFFFF_FFFC;
      default:              mask = '0;
    endcase
    return (old_val & ~mask) | (raw & mask);
  endfunction

  function automatic logic [csr_pkg::XLEN-1:0] model_read(input csr_pkg::csr_addr_t addr);
    case (addr)
      csr_pkg::CSR_MSTATUS: return m_mstatus;
      csr_pkg::CSR_MIE:     return m_mie;
      csr_pkg::CSR_MTVEC:   return m_mtvec;
      csr_pkg::CSR_MEPC:    return m_mepc;
      csr_pkg::CSR_MIP:     return m_mip;
      csr_pkg::CSR_MHARTID: return HART_ID;
      default:              return '0;
    endcase
  endfunction

  // Shadow of the CSR state and the trap sequencer
  always @(posedge clk or negedge rstn) begin : shadow
    logic                     pend;
    logic                     run;
    logic [csr_pkg::XLEN-1:0] next_pc;
    logic [csr_pkg::XLEN-1:0] nxt;
    if (!rstn) begin
      m_mstatus = 32'h0000_1800;  // MPP reads 11
      m_mie     = '0;
      m_mip     = '0;
      m_mtvec   = MTVEC_RESET;
      m_mepc    = '0;
      m_cycles  = '0;
      m_retires = '0;
      m_trap_q  = 1'b0;
      m_ret_q   = 1'b0;
      m_trap_pc = '0;
    end else begin
      pend = m_mip[csr_pkg::MEIP_BIT] & m_mie[csr_pkg::MEIE_BIT] & m_mstatus[csr_pkg::MIE_BIT];
      run = !m_trap_q && !m_ret_q;
      next_pc = pend ? m_mtvec : m_mepc;
      nxt = ref_csr_next(model_read(csr_addr_i), csr_op_i, csr_addr_i, csr_wdata_i);
      if (m_trap_q) begin
        m_mepc = pc_i & 32'hFFFF_FFFC;
        m_mstatus[csr_pkg::MPIE_BIT] = m_mstatus[csr_pkg::MIE_BIT];
        m_mstatus[csr_pkg::MIE_BIT] = 1'b0;
      end else if (m_ret_q) begin
        m_mstatus[csr_pkg::MIE_BIT] = m_mstatus[csr_pkg::MPIE_BIT];
        m_mstatus[csr_pkg::MPIE_BIT] = 1'b1;
      end else if (csr_op_i != csr_pkg::CSR_NONE) begin
        case (csr_addr_i)
          csr_pkg::CSR_MSTATUS: m_mstatus = nxt;
          csr_pkg::CSR_MIE:     m_mie = nxt;
          csr_pkg::CSR_MTVEC:   m_mtvec = nxt;
          csr_pkg::CSR_MEPC:    m_mepc = nxt;
          default: ;  // Read only
        endcase
      end
      if (run && (pend || mret_i)) m_trap_pc = next_pc;
      m_trap_q = run && pend;  // Interrupt wins over mret
      m_ret_q  = run && !pend && mret_i;
      m_mip = irq_i ? (32'h1 << csr_pkg::MEIP_BIT) : '0;
      m_cycles = m_cycles + 64'd1;
      if (retire_i) m_retires = m_retires + 64'd1;
    end
  end

  // Redirect outputs against the model, every cycle
  always @(negedge clk) begin
    if (rstn === 1'b1 && (m_trap_q || m_ret_q || trap_o)) begin
      check_trap("trap_monitor", m_trap_q || m_ret_q, m_trap_pc, trap_o, trap_pc_o);
    end
  end

  task automatic drive(input csr_pkg::csr_op_e op, input csr_pkg::csr_addr_t addr,
                       input logic [csr_pkg::XLEN-1:0] wdata, input logic mret,
                       input logic retire);
    @(negedge clk);
    csr_op_i    = op;
    csr_addr_i  = addr;
    csr_wdata_i = wdata;
    mret_i      = mret;
    retire_i    = retire;
    irq_i       = irq_lvl;
    pc_i        = pc_val;
    #2;  // Settle before sampling
  endtask

  task automatic idle(input int n);
    repeat (n) drive(csr_pkg::CSR_NONE, '0, '0, 1'b0, 1'b0);
  endtask

  task automatic read_expect(input string name, input csr_pkg::csr_addr_t addr,
                             input logic [csr_pkg::XLEN-1:0] exp);
    drive(csr_pkg::CSR_NONE, addr, '0, 1'b0, 1'b0);
    check_data(name, exp, csr_rdata_o);
  endtask

  // Read data is the value before the access
  task automatic access_check(input string name, input csr_pkg::csr_op_e op,
                              input csr_pkg::csr_addr_t addr, input logic [csr_pkg::XLEN-1:0] wdata);
    drive(op, addr, wdata, 1'b0, 1'b0);
    check_data(name, model_read(addr), csr_rdata_o);
  endtask

  // Low half then high half on the next cycle
  task automatic read_counter(input logic cyc, output logic [63:0] act, output logic [63:0] exp);
    drive(csr_pkg::CSR_NONE, cyc ? csr_pkg::CSR_MCYCLE : csr_pkg::CSR_MINSTRET, '0, 1'b0, 1'b0);
    act[31:0] = csr_rdata_o;
    exp[31:0] = cyc ? m_cycles[31:0] : m_retires[31:0];
    drive(csr_pkg::CSR_NONE, cyc ? csr_pkg::CSR_MCYCLEH : csr_pkg::CSR_MINSTRETH, '0, 1'b0, 1'b0);
    act[63:32] = csr_rdata_o;
    exp[63:32] = cyc ? m_cycles[63:32] : m_retires[63:32];
  endtask

  task automatic wait_trap(input string name, output logic seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < 20) begin
      idle(1);
      seen = (trap_o === 1'b1);
      n++;
    end
    if (!seen) begin
      fail_count++;
      $display("Timeout in %s: trap_o did not rise within 20 cycles", name);
    end
  endtask

  task automatic gate_hold(input string name);
    repeat (10) begin
      idle(1);
      check_trap(name, 1'b0, '0, trap_o, trap_pc_o);
    end
  endtask

  initial begin
    seed = 32;
    rstn = 1'b0;
    irq_i = 1'b0;
    mret_i = 1'b0;
    retire_i = 1'b0;
    pc_i = '0;
    csr_op_i = csr_pkg::CSR_NONE;
    csr_addr_i = '0;
    csr_wdata_i = '0;
    irq_lvl = 1'b0;
    pc_val = '0;
    repeat (5) @(negedge clk);
    rstn = 1'b1;

    start_test("reset_values");
    read_expect("mstatus", csr_pkg::CSR_MSTATUS, 32'h0000_1800);
    read_expect("mtvec", csr_pkg::CSR_MTVEC, MTVEC_RESET);
    read_expect("mie", csr_pkg::CSR_MIE, '0);
    read_expect("mip", csr_pkg::CSR_MIP, '0);
    read_expect("mepc", csr_pkg::CSR_MEPC, '0);
    read_expect("mvendorid", csr_pkg::CSR_MVENDORID, '0);
    read_expect("marchid", csr_pkg::CSR_MARCHID, '0);
    read_expect("mimpid", csr_pkg::CSR_MIMPID, '0);
    read_expect("mhartid", csr_pkg::CSR_MHARTID, HART_ID);
    read_expect("unknown", 12'h7C0, '0);
    end_test();

    start_test("csr_ops");
    for (i = 0; i < 40; i++) begin
      case ($unsigned($random(seed)) % 4)
        0:       rnd_addr = csr_pkg::CSR_MSTATUS;
        1:       rnd_addr = csr_pkg::CSR_MIE;
        2:       rnd_addr = csr_pkg::CSR_MTVEC;
        default: rnd_addr = csr_pkg::CSR_MEPC;
      endcase
      op_sel = $unsigned($random(seed)) % 3;
      rnd_op = csr_pkg::csr_op_e'(op_sel[1:0] + 2'd1);
      access_check("old_value", rnd_op, rnd_addr, $random(seed));
    end
    access_check("mstatus_final", csr_pkg::CSR_NONE, csr_pkg::CSR_MSTATUS, '0);
    access_check("mie_final", csr_pkg::CSR_NONE, csr_pkg::CSR_MIE, '0);
    access_check("mtvec_final", csr_pkg::CSR_NONE, csr_pkg::CSR_MTVEC, '0);
    access_check("mepc_final", csr_pkg::CSR_NONE, csr_pkg::CSR_MEPC, '0);
    access_check("mip_write", csr_pkg::CSR_WRITE, csr_pkg::CSR_MIP, '1);
    access_check("mip_kept", csr_pkg::CSR_NONE, csr_pkg::CSR_MIP, '0);
    access_check("mhartid_write", csr_pkg::CSR_WRITE, csr_pkg::CSR_MHARTID, '1);
    access_check("mhartid_kept", csr_pkg::CSR_NONE, csr_pkg::CSR_MHARTID, '0);
    end_test();

    start_test("counters");
    for (i = 0; i < 25; i++) begin
      drive(csr_pkg::CSR_NONE, '0, '0, 1'b0, $random(seed) % 2 != 0);
    end
    read_counter(1'b0, act64, exp64);
    check_count("minstret", exp64, act64);
    read_counter(1'b1, act64, exp64);
    check_count("mcycle", exp64, act64);
    drive(csr_pkg::CSR_NONE, csr_pkg::CSR_MCYCLE, '0, 1'b0, 1'b0);
    a0 = csr_rdata_o;
    idle(16);
    drive(csr_pkg::CSR_NONE, csr_pkg::CSR_MCYCLE, '0, 1'b0, 1'b0);
    a1 = csr_rdata_o;
    check_count("mcycle_delta", 64'd17, {32'b0, a1 - a0});
    end_test();

    start_test("irq_gating");
    access_check("mstatus_clear", csr_pkg::CSR_WRITE, csr_pkg::CSR_MSTATUS, '0);
    access_check("meie_set", csr_pkg::CSR_WRITE, csr_pkg::CSR_MIE, 32'h0000_0800);
    irq_lvl = 1'b1;
    read_expect("mip_same_cycle", csr_pkg::CSR_MIP, '0);
    read_expect("mip_next_cycle", csr_pkg::CSR_MIP, 32'h0000_0800);
    gate_hold("mie_clear");
    access_check("meie_clear", csr_pkg::CSR_WRITE, csr_pkg::CSR_MIE, '0);
    access_check("mie_set", csr_pkg::CSR_SET, csr_pkg::CSR_MSTATUS, 32'h0000_0008);
    gate_hold("meie_clear");
    irq_lvl = 1'b0;
    idle(2);
    end_test();

    start_test("trap_entry");
    pc_val = 32'h0000_4567;
    access_check("meie_enable", csr_pkg::CSR_SET, csr_pkg::CSR_MIE, 32'h0000_0800);
    exp_vec = m_mtvec;
    irq_lvl = 1'b1;
    wait_trap("trap_entry", found);
    if (found) check_trap("redirect", 1'b1, exp_vec, trap_o, trap_pc_o);
    idle(1);
    check_trap("single_pulse", 1'b0, '0, trap_o, trap_pc_o);
    irq_lvl = 1'b0;
    read_expect("mepc", csr_pkg::CSR_MEPC, 32'h0000_4564);
    read_expect("mstatus", csr_pkg::CSR_MSTATUS, 32'h0000_1880);
    end_test();

    start_test("mret");
    idle(2);
    drive(csr_pkg::CSR_NONE, '0, '0, 1'b1, 1'b0);
    wait_trap("mret", found);
    if (found) check_trap("redirect", 1'b1, 32'h0000_4564, trap_o, trap_pc_o);
    idle(1);
    check_trap("single_pulse", 1'b0, '0, trap_o, trap_pc_o);
    read_expect("mstatus", csr_pkg::CSR_MSTATUS, 32'h0000_1888);
    end_test();

    $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== csr_unit.f ====
+incdir+verif
verilog/csr_pkg.sv
verilog/csr_ctrl_if.sv
verilog/trap_fsm.sv
verilog/perf_counters.sv
verilog/csr_regfile.sv
verilog/csr_unit.sv
verif/tb_csr_unit.sv
